// File: Bender.yml
package:
  name: i3c_engine

sources:
  - include_dirs:
      - hw
    files:
      - hw/i3c_engine_pkg.sv
      - hw/arb_addr_decoder.sv
      - hw/bus_sequencer.sv
      - hw/route_select.sv
      - hw/i3c_engine.sv
  - target: test
    include_dirs:
      - hw
    files:
      - sim/i3c_engine_tb.sv

// File: all.f
+incdir+hw
hw/i3c_engine_pkg.sv
hw/arb_addr_decoder.sv
hw/bus_sequencer.sv
hw/route_select.sv
hw/i3c_engine.sv
sim/i3c_engine_tb.sv

// File: hw/arb_addr_decoder.sv
/* arbitration read-back: waits for the received address, reads it
   back from the register file and classifies it as hj, ibi or crh */
`timescale 1ns/1ns
`include "i3c_defs.svh"

module arb_addr_decoder (
  input  logic                       i_clk,
  input  logic                       i_rst_n,
  input  logic                       i_arb_active,    // sequencer sits in ARB
  input  logic                       i_rx_mode_done,
  input  logic                       i_scl_neg_edge,
  input  logic [`I3C_DATA_W-1:0]     i_regf_data_rd,
  output logic                       o_rx_data_valid,
  output logic                       o_regf_rd_en,
  output i3c_engine_pkg::arb_req_t   o_arb_req
);

  import i3c_engine_pkg::*;

  logic rd_pend;     // address written, read-back not started yet
  logic addr_ready;  // register file output holds the address

  always_ff @(posedge i_clk or negedge i_rst_n)
  begin
    if (!i_rst_n)
    begin
      o_rx_data_valid <= 1'b0;
      o_regf_rd_en    <= 1'b0;
      o_arb_req       <= '0;
      rd_pend         <= 1'b0;
      addr_ready      <= 1'b0;
    end
    else if (!i_arb_active)
    begin
      // nothing lost, or sequencer already moved on
      o_rx_data_valid <= 1'b0;
      o_regf_rd_en    <= 1'b0;
      o_arb_req       <= '0;
      rd_pend         <= 1'b0;
      addr_ready      <= 1'b0;
    end
    else
    begin
      o_rx_data_valid <= 1'b0;  // pulse
      o_arb_req       <= '0;    // pulse
      if (i_rx_mode_done && i_scl_neg_edge && !rd_pend && !o_regf_rd_en)
      begin
        o_rx_data_valid <= 1'b1;  // rx writes the address byte
        rd_pend         <= 1'b1;
      end
      else if (addr_ready && i_scl_neg_edge)
      begin
        // reserved hj address with write bit, else rnw picks ibi or crh
        if (i_regf_data_rd == {`I3C_HJ_ADDR, 1'b0})
          o_arb_req.hj <= 1'b1;
        else if (i_regf_data_rd[0])
          o_arb_req.ibi <= 1'b1;
        else
          o_arb_req.crh <= 1'b1;
        addr_ready   <= 1'b0;
        o_regf_rd_en <= 1'b0;
      end
      else if (rd_pend && o_regf_rd_en)
      begin
        addr_ready <= 1'b1;
        rd_pend    <= 1'b0;
      end
      else if (rd_pend)
        o_regf_rd_en <= 1'b1;
    end
  end

endmodule

// File: hw/bus_sequencer.sv
/* main controller state machine: start, block hand-over, stop,
   arbitration recovery and hot-join chaining */
`timescale 1ns/1ns
`include "i3c_defs.svh"

module bus_sequencer (
  input  logic                        i_clk,
  input  logic                        i_rst_n,
  input  logic                        i_controller_en,
  input  logic                        i_i3c_i2c_sel,      // 1 i3c, 0 legacy i2c
  input  logic                        i_ccc_en_dis_hj,
  input  logic                        i_tx_mode_done,
  input  logic                        i_rx_arbitration_lost,
  input  logic                        i_sdr_done,
  input  logic                        i_i2c_done,
  input  logic                        i_daa_done,
  input  logic                        i_daa_error,
  input  logic                        i_hj_done,
  input  logic                        i_hj_daa_req,
  input  logic                        i_hj_cr_pass,
  input  logic                        i_ibi_done,
  input  logic                        i_crh_done,
  input  i3c_engine_pkg::arb_req_t    i_arb_req,
  output logic                        o_arb_active,
  output logic                        o_sdr_en,
  output logic                        o_i2c_en,
  output logic                        o_daa_en,
  output logic                        o_hj_en,
  output logic                        o_hj_ccc,
  output logic                        o_hj_daa_en,
  output logic                        o_hj_crh_en,
  output logic                        o_ibi_en,
  output logic                        o_crh_en,
  output logic                        o_tx_en,
  output logic                        o_pp_od,
  output logic                        o_scl_idle,
  output logic                        o_bit_cnt_en,
  output logic                        o_controller_done,
  output logic                        o_i3c_idle_flag,
  output logic [`I3C_TXMODE_W-1:0]    o_tx_mode,
  output i3c_engine_pkg::grant_t      o_grant
);

  import i3c_engine_pkg::*;

  seq_state_e state;
  logic       dyn_addr_assigned;  // set once daa completes

  // decoder runs only while here
  assign o_arb_active = (state == ST_ARB);

  always_ff @(posedge i_clk or negedge i_rst_n)
  begin
    if (!i_rst_n)
    begin
      state             <= ST_IDLE;
      dyn_addr_assigned <= 1'b0;
      o_sdr_en          <= 1'b0;
      o_i2c_en          <= 1'b0;
      o_daa_en          <= 1'b0;
      o_hj_en           <= 1'b0;
      o_hj_ccc          <= 1'b0;
      o_hj_daa_en       <= 1'b0;
      o_hj_crh_en       <= 1'b0;
      o_ibi_en          <= 1'b0;
      o_crh_en          <= 1'b0;
      o_tx_en           <= 1'b0;
      o_tx_mode         <= TX_START;
      o_pp_od           <= 1'b0;
      o_scl_idle        <= 1'b1;
      o_bit_cnt_en      <= 1'b0;
      o_controller_done <= 1'b0;
      o_i3c_idle_flag   <= 1'b0;
      o_grant           <= '{owner: OWN_ENGINE, bus_only: 1'b0};
    end
    else
    begin
      o_controller_done <= 1'b0;
      o_i3c_idle_flag   <= 1'b0;
      case (state)
        ST_IDLE:
        begin
          o_scl_idle <= 1'b1;
          o_grant    <= '{owner: OWN_ENGINE, bus_only: 1'b0};
          if (i_controller_en)
          begin
            o_tx_en    <= 1'b1;
            o_tx_mode  <= TX_START;
            o_scl_idle <= 1'b0;
            o_grant    <= '{owner: OWN_ENGINE, bus_only: 1'b1};
            state      <= ST_START;
          end
          else if (i_rx_arbitration_lost)
            state <= ST_ARB;  // target won the header
        end

        ST_START:
        begin
          if (i_tx_mode_done)
          begin
            o_tx_en <= 1'b0;
            if (i_ccc_en_dis_hj)
            begin
              o_hj_en  <= 1'b1;
              o_hj_ccc <= 1'b1;  // enhj/dishj broadcast
              o_grant  <= '{owner: OWN_HJ, bus_only: 1'b0};
              state    <= ST_HOT_JOIN;
            end
            else if (i_i3c_i2c_sel && !dyn_addr_assigned)
            begin
              o_daa_en <= 1'b1;
              o_grant  <= '{owner: OWN_DAA, bus_only: 1'b0};
              state    <= ST_DAA;
            end
            else if (i_i3c_i2c_sel)
            begin
              o_sdr_en     <= 1'b1;
              o_bit_cnt_en <= 1'b1;
              o_grant      <= '{owner: OWN_SDR, bus_only: 1'b0};
              state        <= ST_SDR;
            end
            else
            begin
              o_i2c_en     <= 1'b1;
              o_bit_cnt_en <= 1'b1;
              o_grant      <= '{owner: OWN_I2C, bus_only: 1'b0};
              state        <= ST_I2C;
            end
          end
        end

        ST_SDR, ST_I2C:
        begin
          if (i_rx_arbitration_lost)
          begin
            o_sdr_en     <= 1'b0;
            o_i2c_en     <= 1'b0;
            o_bit_cnt_en <= 1'b0;
            o_grant      <= '{owner: OWN_ENGINE, bus_only: 1'b0};
            state        <= ST_ARB;
          end
          else if ((state == ST_SDR) ? i_sdr_done : i_i2c_done)
          begin
            o_sdr_en     <= 1'b0;
            o_i2c_en     <= 1'b0;
            o_bit_cnt_en <= 1'b0;
            o_tx_en      <= 1'b1;
            o_tx_mode    <= TX_STOP;
            o_pp_od      <= (state == ST_SDR);  // legacy stop stays open-drain
            o_scl_idle   <= 1'b1;
            o_grant      <= '{owner: OWN_ENGINE, bus_only: 1'b1};
            state        <= ST_STOP;
          end
        end

        ST_DAA:
        begin
          if (i_rx_arbitration_lost || i_daa_error || i_daa_done)
          begin
            o_daa_en    <= 1'b0;
            o_hj_daa_en <= 1'b0;
          end
          if (i_rx_arbitration_lost)
          begin
            o_grant <= '{owner: OWN_ENGINE, bus_only: 1'b0};
            state   <= ST_ARB;
          end
          else if (i_daa_error)
          begin
            o_grant <= '{owner: OWN_ENGINE, bus_only: 1'b0};
            state   <= ST_IDLE;  // abandon, no stop
          end
          else if (i_daa_done)
          begin
            dyn_addr_assigned <= 1'b1;
            o_tx_en           <= 1'b1;
            o_tx_mode         <= TX_STOP;
            o_pp_od           <= 1'b1;
            o_scl_idle        <= 1'b1;
            o_grant           <= '{owner: OWN_ENGINE, bus_only: 1'b1};
            state             <= ST_STOP;
          end
        end

        ST_HOT_JOIN:
        begin
          if (i_hj_done)
          begin
            o_hj_en  <= 1'b0;
            o_hj_ccc <= 1'b0;
            if (i_hj_daa_req)
            begin
              o_daa_en    <= 1'b1;
              o_hj_daa_en <= 1'b1;
              o_grant     <= '{owner: OWN_DAA, bus_only: 1'b0};
              state       <= ST_DAA;
            end
            else if (i_hj_cr_pass)
            begin
              o_crh_en    <= 1'b1;
              o_hj_crh_en <= 1'b1;
              o_grant     <= '{owner: OWN_CRH, bus_only: 1'b0};
              state       <= ST_CTRL_REQ;
            end
            else
            begin
              o_tx_en    <= 1'b1;
              o_tx_mode  <= TX_STOP;
              o_pp_od    <= 1'b1;
              o_scl_idle <= 1'b1;
              o_grant    <= '{owner: OWN_ENGINE, bus_only: 1'b1};
              state      <= ST_STOP;
            end
          end
        end

        ST_ARB:
        begin
          o_tx_en <= 1'b0;
          if (i_arb_req.hj)
          begin
            o_hj_en  <= 1'b1;
            o_hj_ccc <= 1'b0;  // target-initiated, not a ccc
            o_grant  <= '{owner: OWN_HJ, bus_only: 1'b0};
            state    <= ST_HOT_JOIN;
          end
          else if (i_arb_req.ibi)
          begin
            o_ibi_en <= 1'b1;
            o_grant  <= '{owner: OWN_IBI, bus_only: 1'b0};
            state    <= ST_IBI;
          end
          else if (i_arb_req.crh)
          begin
            o_crh_en    <= 1'b1;
            o_hj_crh_en <= 1'b0;
            o_grant     <= '{owner: OWN_CRH, bus_only: 1'b0};
            state       <= ST_CTRL_REQ;
          end
        end

        ST_IBI:
        begin
          if (i_ibi_done)
          begin
            o_ibi_en <= 1'b0;
            o_grant  <= '{owner: OWN_ENGINE, bus_only: 1'b1};
            state    <= ST_IDLE;
          end
        end

        ST_CTRL_REQ:
        begin
          if (i_crh_done)
          begin
            o_crh_en    <= 1'b0;
            o_hj_crh_en <= 1'b0;
            o_pp_od     <= 1'b0;
            o_grant     <= '{owner: OWN_ENGINE, bus_only: 1'b1};
            state       <= ST_IDLE;
          end
        end

        ST_STOP:
        begin
          if (i_tx_mode_done)
          begin
            o_tx_en           <= 1'b0;
            o_pp_od           <= 1'b0;
            o_controller_done <= 1'b1;
            o_i3c_idle_flag   <= 1'b1;
            o_grant           <= '{owner: OWN_ENGINE, bus_only: 1'b0};
            state             <= ST_IDLE;
          end
        end

        default: state <= ST_IDLE;
      endcase
    end
  end

endmodule

// File: hw/i3c_defs.svh
/* widths, reserved hot-join address and tx mode codes
   shared by the engine package and the stages */
`ifndef I3C_DEFS_SVH
`define I3C_DEFS_SVH

// owner select code for the datapath muxes
`define I3C_SEL_W     3

// tx mode code driven to the serializer
`define I3C_TXMODE_W  3

// register file byte
`define I3C_DATA_W    8

// reserved address a target uses to request hot-join
`define I3C_HJ_ADDR   7'h02

// tx mode codes
`define I3C_TX_START  3'b000
`define I3C_TX_STOP   3'b010

`endif

// File: hw/i3c_engine.sv
/* i3c controller sequencer top: arbitration decoder, bus sequencer
   and route select */
`timescale 1ns/1ns
`include "i3c_defs.svh"

module i3c_engine (
  input  logic                       i_clk,
  input  logic                       i_rst_n,
  input  logic                       i_controller_en,
  input  logic                       i_i3c_i2c_sel,
  input  logic                       i_ccc_en_dis_hj,
  input  logic                       i_tx_mode_done,
  input  logic                       i_rx_mode_done,
  input  logic                       i_rx_arbitration_lost,
  input  logic                       i_scl_neg_edge,
  input  logic [`I3C_DATA_W-1:0]     i_regf_data_rd,
  input  logic                       i_sdr_done,
  input  logic                       i_i2c_done,
  input  logic                       i_daa_done,
  input  logic                       i_daa_error,
  input  logic                       i_hj_done,
  input  logic                       i_hj_daa_req,
  input  logic                       i_hj_cr_pass,
  input  logic                       i_ibi_done,
  input  logic                       i_crh_done,
  output logic                       o_sdr_en,
  output logic                       o_i2c_en,
  output logic                       o_daa_en,
  output logic                       o_hj_en,
  output logic                       o_hj_ccc,
  output logic                       o_hj_daa_en,
  output logic                       o_hj_crh_en,
  output logic                       o_ibi_en,
  output logic                       o_crh_en,
  output logic                       o_tx_en,
  output logic [`I3C_TXMODE_W-1:0]   o_tx_mode,
  output logic                       o_pp_od,
  output logic                       o_scl_idle,
  output logic                       o_bit_cnt_en,
  output logic                       o_controller_done,
  output logic                       o_i3c_idle_flag,
  output logic                       o_rx_data_valid,
  output logic                       o_regf_rd_en,
  output i3c_engine_pkg::route_t     o_route
);

  import i3c_engine_pkg::*;

  arb_req_t arb_req;     // decoder -> sequencer
  grant_t   grant;       // sequencer -> routing
  logic     arb_active;

  arb_addr_decoder u_arb_dec (
    .i_clk, .i_rst_n,
    .i_arb_active (arb_active),
    .i_rx_mode_done, .i_scl_neg_edge, .i_regf_data_rd,
    .o_rx_data_valid, .o_regf_rd_en,
    .o_arb_req    (arb_req)
  );

  bus_sequencer u_seq (
    .i_clk, .i_rst_n,
    .i_controller_en, .i_i3c_i2c_sel, .i_ccc_en_dis_hj, .i_tx_mode_done,
    .i_rx_arbitration_lost, .i_sdr_done, .i_i2c_done, .i_daa_done,
    .i_daa_error, .i_hj_done, .i_hj_daa_req, .i_hj_cr_pass,
    .i_ibi_done, .i_crh_done,
    .i_arb_req    (arb_req),
    .o_arb_active (arb_active),
    .o_sdr_en, .o_i2c_en, .o_daa_en, .o_hj_en, .o_hj_ccc,
    .o_hj_daa_en, .o_hj_crh_en, .o_ibi_en, .o_crh_en,
    .o_tx_en, .o_pp_od, .o_scl_idle, .o_bit_cnt_en,
    .o_controller_done, .o_i3c_idle_flag, .o_tx_mode,
    .o_grant      (grant)
  );

  route_select u_route (
    .i_clk, .i_rst_n,
    .i_grant (grant),
    .o_route
  );

endmodule

// File: hw/i3c_engine_pkg.sv
/* owner, sequencer state and tx mode enums; arbitration request,
   grant and route structs for the engine stages */
package i3c_engine_pkg;

`include "i3c_defs.svh"

  // datapath owner codes, one per block sharing the bus
  typedef enum logic [`I3C_SEL_W-1:0] {
    OWN_SDR    = 3'b000,
    OWN_I2C    = 3'b001,
    OWN_ENGINE = 3'b010,
    OWN_DAA    = 3'b011,
    OWN_HJ     = 3'b100,
    OWN_IBI    = 3'b101,
    OWN_CRH    = 3'b110
  } owner_e;

  // sequencer states, gray-style
  typedef enum logic [3:0] {
    ST_IDLE     = 4'b0000,
    ST_START    = 4'b0001,
    ST_SDR      = 4'b0010,
    ST_IBI      = 4'b0011,
    ST_DAA      = 4'b0100,
    ST_I2C      = 4'b0110,
    ST_CTRL_REQ = 4'b1010,
    ST_ARB      = 4'b1100,
    ST_HOT_JOIN = 4'b1110,
    ST_STOP     = 4'b1111
  } seq_state_e;

  typedef enum logic [`I3C_TXMODE_W-1:0] {
    TX_START = `I3C_TX_START,
    TX_STOP  = `I3C_TX_STOP
  } tx_mode_e;

  // one-hot class of the arbitrated address, one-cycle pulses
  typedef struct packed {
    logic hj;
    logic ibi;
    logic crh;
  } arb_req_t;

  typedef struct packed {
    owner_e owner;
    logic   bus_only;  // engine takes back bus-facing muxes only
  } grant_t;

  ////////////////////////////////////////////////////
  // per-resource mux selects of the shared datapath
  ////////////////////////////////////////////////////
  typedef struct packed {
    owner_e regf_rd_en;
    owner_e regf_rd_addr;
    owner_e regf_wr_en;
    owner_e scl_pp_od;     // bus-facing from here
    owner_e tx_en;
    owner_e tx_mode;
    owner_e scl_idle;
    owner_e ser_rx_tx;
    owner_e bits_cnt;
    owner_e rx_en;         // receive and counters
    owner_e rx_mode;
    owner_e bit_cnt_en;
    owner_e bit_rx_cnt_en;
    owner_e fcnt_en;
    owner_e fcnt_no_frms;
  } route_t;

endpackage

// File: hw/route_select.sv
/* registered datapath mux selects, updated from the sequencer grant */
`timescale 1ns/1ns

module route_select (
  input  logic                    i_clk,
  input  logic                    i_rst_n,
  input  i3c_engine_pkg::grant_t  i_grant,
  output i3c_engine_pkg::route_t  o_route
);

  import i3c_engine_pkg::*;

  // every resource to one owner
  function automatic route_t all_to(input owner_e owner);
    route_t r;
    r.regf_rd_en    = owner;
    r.regf_rd_addr  = owner;
    r.regf_wr_en    = owner;
    r.scl_pp_od     = owner;
    r.tx_en         = owner;
    r.tx_mode       = owner;
    r.scl_idle      = owner;
    r.ser_rx_tx     = owner;
    r.bits_cnt      = owner;
    r.rx_en         = owner;
    r.rx_mode       = owner;
    r.bit_cnt_en    = owner;
    r.bit_rx_cnt_en = owner;
    r.fcnt_en       = owner;
    r.fcnt_no_frms  = owner;
    return r;
  endfunction

  //////////////////////////////////////////////////
  // full hand-over or bus-only hand-back
  //////////////////////////////////////////////////
  always_ff @(posedge i_clk or negedge i_rst_n)
  begin
    if (!i_rst_n)
      o_route <= all_to(OWN_ENGINE);
    else if (i_grant.bus_only)
    begin
      // engine drives start/stop, regf and counters keep last owner
      o_route.scl_pp_od <= OWN_ENGINE;
      o_route.tx_en     <= OWN_ENGINE;
      o_route.tx_mode   <= OWN_ENGINE;
      o_route.scl_idle  <= OWN_ENGINE;
      o_route.ser_rx_tx <= OWN_ENGINE;
      o_route.bits_cnt  <= OWN_ENGINE;
    end
    else
      o_route <= all_to(i_grant.owner);
  end

endmodule

// File: sim/i3c_engine_tb.sv
/* testbench for the i3c engine sequencer: file-driven transfers, hot-join
   chaining, arbitration read-back and daa error, with lfsr block delays */
`timescale 1ns/1ns
`include "i3c_defs.svh"

module i3c_engine_tb;

  import i3c_engine_pkg::*;

  localparam int WAIT_MAX = 60;  // bound on any single wait, in cycles

  logic        i_clk, i_rst_n;
  logic        i_controller_en, i_i3c_i2c_sel, i_ccc_en_dis_hj, i_tx_mode_done;
  logic        i_rx_mode_done, i_rx_arbitration_lost, i_scl_neg_edge;
  logic [`I3C_DATA_W-1:0] i_regf_data_rd;
  logic        i_sdr_done, i_i2c_done, i_daa_done, i_daa_error;
  logic        i_hj_done, i_hj_daa_req, i_hj_cr_pass, i_ibi_done, i_crh_done;
  logic        o_sdr_en, o_i2c_en, o_daa_en, o_hj_en, o_hj_ccc, o_hj_daa_en;
  logic        o_hj_crh_en, o_ibi_en, o_crh_en, o_tx_en, o_pp_od, o_scl_idle;
  logic        o_bit_cnt_en, o_controller_done, o_i3c_idle_flag;
  logic        o_rx_data_valid, o_regf_rd_en;
  logic [`I3C_TXMODE_W-1:0] o_tx_mode;
  route_t      o_route;

  // test vectors from the data file
  string       q_name[$];
  string       q_kind[$];
  string       q_en[$];
  logic        q_sel[$];
  logic        q_hjc[$];
  logic        q_dreq[$];
  logic        q_crp[$];
  logic [7:0]  q_addr[$];
  logic [2:0]  q_own[$];

  int          num_tests = 0;
  int          errors = 0;
  int          fail_tests = 0;
  int          done_cnt = 0;
  int          stop_cnt = 0;
  string       cur_name = "reset";
  logic [31:0] lfsr_state = 32'hd3679f65;

  i3c_engine UUT (.*);

  initial i_clk = 1'b0;
  always #50 i_clk = ~i_clk;  // 100 ns period

  // pulses counted on the posedge, read back on the negedge
  always @(posedge i_clk)
  begin
    if (o_controller_done === 1'b1)
      done_cnt++;
    if (o_tx_en === 1'b1 && o_tx_mode == `I3C_TX_STOP)
      stop_cnt++;
  end

  //////////////////////////////////////////////////
  // helpers
  //////////////////////////////////////////////////
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  // 1 to 4 cycles, one lfsr step per bit
  task automatic rand_delay(output int cycles);
    int b;
    cycles = 1;
    for (b = 0; b < 2; b++)
    begin
      lfsr_state = lfsr_next(lfsr_state);
      cycles += int'(lfsr_state[0]) << b;
    end
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) @(negedge i_clk);
  endtask

  function automatic logic [44:0] route_all(input logic [2:0] own);
    return {15{own}};
  endfunction

  // bus-facing selects back to the engine, regf and counters kept
  function automatic logic [44:0] route_bus_back(input logic [2:0] own);
    return {{3{own}}, {6{OWN_ENGINE}}, {6{own}}};
  endfunction

  function automatic string active_enable();
    if (o_daa_en) return "daa";
    if (o_sdr_en) return "sdr";
    if (o_i2c_en) return "i2c";
    if (o_hj_en) return "hj";
    if (o_ibi_en) return "ibi";
    if (o_crh_en) return "crh";
    if (o_tx_en && o_tx_mode == `I3C_TX_STOP) return "stop";
    return "none";
  endfunction

  task automatic value_mismatch(input string what, input logic [63:0] exp,
                                input logic [63:0] act);
    $display("CHECK FAILED %s %s: expected %0h, actual %0h", cur_name, what, exp, act);
    errors++;
  endtask

  task automatic name_mismatch(input string what, input string exp, input string act);
    $display("CHECK FAILED %s %s: expected %s, actual %s", cur_name, what, exp, act);
    errors++;
  endtask

  task automatic timed_out(input string what);
    $display("test %s: timed out waiting for %s", cur_name, what);
    errors++;
  endtask

  task automatic check_route(input string what, input logic [44:0] exp);
    @(negedge i_clk);
    if (o_route !== exp)
      value_mismatch(what, exp, o_route);
  endtask

  // one-cycle pulse after a random delay, driven on the falling edge
  task automatic pulse_input(input string which);
    int d;
    rand_delay(d);
    idle_cycles(d);
    if (which == "tx") i_tx_mode_done = 1'b1;
    else if (which == "sdr") i_sdr_done = 1'b1;
    else if (which == "i2c") i_i2c_done = 1'b1;
    else if (which == "daa") i_daa_done = 1'b1;
    else if (which == "daa_err") i_daa_error = 1'b1;
    else if (which == "hj") i_hj_done = 1'b1;
    else if (which == "ibi") i_ibi_done = 1'b1;
    else if (which == "crh") i_crh_done = 1'b1;
    else if (which == "scl") i_scl_neg_edge = 1'b1;
    @(negedge i_clk);
    {i_tx_mode_done, i_sdr_done, i_i2c_done, i_daa_done, i_daa_error,
     i_hj_done, i_ibi_done, i_crh_done, i_scl_neg_edge} = '0;
  endtask

  task automatic wait_change(input string from, output string got);
    int n;
    n = 0;
    got = active_enable();
    while (got == from && n < WAIT_MAX)
    begin
      @(negedge i_clk);
      got = active_enable();
      n++;
    end
    if (got == from)
      timed_out({"a change from ", from});
  endtask

  //////////////////////////////////////////////////
  // stop phase, block completion, test kinds
  //////////////////////////////////////////////////
  task automatic finish_stop(input logic pp_exp, input logic [2:0] own);
    int n;
    int done0;
    done0 = done_cnt;
    if (o_pp_od !== pp_exp)
      value_mismatch("pp_od at stop", pp_exp, o_pp_od);
    check_route("route at stop", route_bus_back(own));
    pulse_input("tx");
    n = 0;
    while (o_controller_done !== 1'b1 && n < WAIT_MAX)
    begin
      @(negedge i_clk);
      n++;
    end
    if (o_controller_done !== 1'b1)
      timed_out("controller done");
    else if (o_i3c_idle_flag !== 1'b1)
      value_mismatch("idle flag", 1, o_i3c_idle_flag);
    idle_cycles(3);
    if (done_cnt - done0 != 1)
      value_mismatch("done pulses", 1, done_cnt - done0);
    if (o_route !== route_all(OWN_ENGINE))
      value_mismatch("route in idle", route_all(OWN_ENGINE), o_route);
  endtask

  task automatic finish_block(input string name, input logic [2:0] own);
    string got;
    if (name == "stop")
      finish_stop(1'b1, own);
    else
    begin
      check_route("route", route_all(own));
      // bit counter runs during sdr and i2c frames
      if (o_bit_cnt_en !== (name == "sdr" || name == "i2c"))
        value_mismatch("bit_cnt_en", (name == "sdr" || name == "i2c"), o_bit_cnt_en);
      pulse_input(name);
      wait_change(name, got);
      if (name == "ibi" || name == "crh")
      begin
        if (got != "none")
          name_mismatch("after done", "none", got);
        check_route("route after return", route_bus_back(own));
      end
      else if (got != "stop")
        name_mismatch("after done", "stop", got);
      else
        finish_stop(name != "i2c", own);  // legacy stop is open-drain
    end
  endtask

  task automatic run_transfer(input int t);
    string      got;
    string      first;
    logic [2:0] own;
    int         stop0;
    int         done0;
    first = (q_kind[t] == "hjccc") ? "hj" : q_en[t];
    own = (q_kind[t] == "hjccc") ? OWN_HJ : q_own[t];
    i_controller_en = 1'b1;
    @(negedge i_clk);
    i_controller_en = 1'b0;
    if (o_tx_en !== 1'b1 || o_tx_mode !== `I3C_TX_START)
      value_mismatch("start request", {1'b1, `I3C_TX_START}, {o_tx_en, o_tx_mode});
    pulse_input("tx");
    wait_change("none", got);
    if (got != first)
      name_mismatch("enable", first, got);
    else if (q_kind[t] == "daaerr")
    begin
      stop0 = stop_cnt;
      done0 = done_cnt;
      check_route("route", route_all(own));
      pulse_input("daa_err");
      idle_cycles(4);
      if (o_daa_en !== 1'b0)
        value_mismatch("daa_en after error", 0, o_daa_en);
      if (stop_cnt != stop0)
        value_mismatch("stop cycles", 0, stop_cnt - stop0);
      if (done_cnt != done0)
        value_mismatch("done pulses", 0, done_cnt - done0);
      if (o_route !== route_all(OWN_ENGINE))
        value_mismatch("route after error", route_all(OWN_ENGINE), o_route);
    end
    else if (q_kind[t] == "hjccc")
    begin
      if (o_hj_ccc !== 1'b1)
        value_mismatch("hj_ccc", 1, o_hj_ccc);
      check_route("route", route_all(own));
      i_hj_daa_req = q_dreq[t];
      i_hj_cr_pass = q_crp[t];
      pulse_input("hj");
      i_hj_daa_req = 1'b0;
      i_hj_cr_pass = 1'b0;
      wait_change("hj", got);
      if (got != q_en[t])
        name_mismatch("chained enable", q_en[t], got);
      else
      begin
        if (got == "daa" && o_hj_daa_en !== 1'b1)
          value_mismatch("hj_daa_en", 1, o_hj_daa_en);
        if (got == "crh" && o_hj_crh_en !== 1'b1)
          value_mismatch("hj_crh_en", 1, o_hj_crh_en);
        finish_block(got, q_own[t]);
      end
    end
    else
      finish_block(got, own);
  endtask

  // lost arbitration from idle, address read back from the register file
  task automatic arb_sequence(input int t);
    string got;
    i_rx_arbitration_lost = 1'b1;
    @(negedge i_clk);
    i_rx_arbitration_lost = 1'b0;
    i_rx_mode_done = 1'b1;
    i_scl_neg_edge = 1'b1;
    @(negedge i_clk);
    i_rx_mode_done = 1'b0;
    i_scl_neg_edge = 1'b0;
    if (o_rx_data_valid !== 1'b1)
      value_mismatch("rx_data_valid", 1, o_rx_data_valid);
    @(negedge i_clk);
    if (o_regf_rd_en !== 1'b1)
      value_mismatch("regf_rd_en", 1, o_regf_rd_en);
    pulse_input("scl");
    wait_change("none", got);
    if (got != q_en[t])
      name_mismatch("arbitration class", q_en[t], got);
    else
    begin
      if (got == "hj" && o_hj_ccc !== 1'b0)
        value_mismatch("hj_ccc", 0, o_hj_ccc);
      finish_block(got, q_own[t]);
    end
  endtask

  task automatic run_test(input int t);
    int err0;
    err0 = errors;
    cur_name = q_name[t];
    i_regf_data_rd = q_addr[t];
    i_i3c_i2c_sel = q_sel[t];
    i_ccc_en_dis_hj = q_hjc[t];
    if (q_kind[t] == "arb")
      arb_sequence(t);
    else
      run_transfer(t);
    idle_cycles(2);
    if (errors == err0)
      $display("test %s: ok", cur_name);
    else
    begin
      fail_tests++;
      $display("test %s: %0d check(s) failed", cur_name, errors - err0);
    end
  endtask

  //////////////////////////////////////////////////
  // main sequence and watchdog
  //////////////////////////////////////////////////
  initial
  begin
    int         fd;
    int         r;
    int         c;
    int         t;
    int         sel_i, hjc_i, dreq_i, crp_i, own_i;
    logic [7:0] addr_v;
    string      tok, kind_s, en_s;
    i_rst_n = 1'b0;
    {i_controller_en, i_i3c_i2c_sel, i_ccc_en_dis_hj, i_tx_mode_done} = '0;
    {i_rx_mode_done, i_rx_arbitration_lost, i_scl_neg_edge} = '0;
    {i_sdr_done, i_i2c_done, i_daa_done, i_daa_error} = '0;
    {i_hj_done, i_hj_daa_req, i_hj_cr_pass, i_ibi_done, i_crh_done} = '0;
    i_regf_data_rd = '0;
    fd = $fopen("sim/i3c_engine_testdata.txt", "r");
    if (fd == 0)
    begin
      $display("cannot open sim/i3c_engine_testdata.txt");
      errors++;
    end
    else
    begin
      while ($fscanf(fd, "%s", tok) == 1)
      begin
        if (tok.substr(0, 0) == "#")
        begin
          c = $fgetc(fd);  // skip the comment line
          while (c != "\n" && c != -1)
            c = $fgetc(fd);
        end
        else
        begin
          r = $fscanf(fd, "%s %d %d %d %d %h %s %d", kind_s, sel_i, hjc_i, dreq_i,
                      crp_i, addr_v, en_s, own_i);
          if (r != 8)
          begin
            $display("malformed test data line after %s", tok);
            errors++;
          end
          q_name.push_back(tok);
          q_kind.push_back(kind_s);
          q_en.push_back(en_s);
          q_sel.push_back(sel_i != 0);
          q_hjc.push_back(hjc_i != 0);
          q_dreq.push_back(dreq_i != 0);
          q_crp.push_back(crp_i != 0);
          q_addr.push_back(addr_v);
          q_own.push_back(own_i[2:0]);
        end
      end
      $fclose(fd);
      num_tests = q_name.size();
    end
    if (num_tests == 0)
    begin
      $display("no tests found in the test data file");
      errors++;
    end

    repeat (8) @(negedge i_clk);
    i_rst_n = 1'b1;
    @(negedge i_clk);
    // idle outputs after reset
    if (o_scl_idle !== 1'b1)
      value_mismatch("scl_idle", 1, o_scl_idle);
    if (o_tx_en !== 1'b0)
      value_mismatch("tx_en", 0, o_tx_en);
    if ({o_hj_ccc, o_hj_daa_en, o_hj_crh_en, o_pp_od, o_bit_cnt_en} !== 5'b0)
      value_mismatch("flags", 5'b0,
                     {o_hj_ccc, o_hj_daa_en, o_hj_crh_en, o_pp_od, o_bit_cnt_en});
    if (active_enable() != "none")
      name_mismatch("enable", "none", active_enable());
    if (o_route !== route_all(OWN_ENGINE))
      value_mismatch("route", route_all(OWN_ENGINE), o_route);
    $display("test reset: %s", (errors == 0) ? "ok" : "check(s) failed");

    for (t = 0; t < num_tests; t++)
      run_test(t);

    $display("%0d tests run, %0d failed, %0d errors", num_tests, fail_tests, errors);
    if (errors == 0)
      $display("*** TEST PASSED ***");
    else
      $display("*** TEST FAILED ***");
    $finish;
  end

  // 400 cycles per test from the data file
  initial
  begin
    wait (num_tests > 0);
    #(num_tests * 400 * 100);
    $display("watchdog expired after %0d cycles", num_tests * 400);
    $display("*** TEST FAILED ***");
    $finish;
  end

endmodule

// File: sim/i3c_engine_testdata.txt
# name kind sel hj_ccc hj_daa_req hj_cr_pass arb_addr(hex) exp_enable exp_owner
# kinds xfer daaerr hjccc arb; owners sdr=0 i2c=1 engine=2 daa=3 hj=4 ibi=5 crh=6
# hjccc lines give the enable chained after hot-join, stop keeps the hj owner
daa_error      daaerr 1 0 0 0 00 daa  3
i3c_first_daa  xfer   1 0 0 0 00 daa  3
i3c_sdr        xfer   1 0 0 0 00 sdr  0
i2c_legacy     xfer   0 0 0 0 00 i2c  1
i3c_sdr_again  xfer   1 0 0 0 00 sdr  0
hj_ccc_stop    hjccc  1 1 0 0 00 stop 4
hj_ccc_daa     hjccc  1 1 1 0 00 daa  3
hj_ccc_crh     hjccc  0 1 0 1 00 crh  6
arb_hj_write   arb    1 0 0 0 04 hj   4
arb_ibi_read   arb    1 0 0 0 a5 ibi  5
arb_hj_read    arb    1 0 0 0 05 ibi  5
arb_crh        arb    1 0 0 0 5a crh  6
arb_crh_zero   arb    1 0 0 0 00 crh  6
i2c_after_arb  xfer   0 0 0 0 00 i2c  1
